/* Bender.yml */
package:
  name: pe_row

sources:
  - verilog/sysRowPkg.sv
  - verilog/actLinkIf.sv
  - verilog/processingElement.sv
  - verilog/rrArbiter.sv
  - verilog/psumRequant.sv
  - verilog/rowCtrl.sv
  - verilog/peRow.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/peRowTb.sv

/* sim.f */
verilog/sysRowPkg.sv
verilog/actLinkIf.sv
verilog/processingElement.sv
verilog/rrArbiter.sv
verilog/psumRequant.sv
verilog/rowCtrl.sv
verilog/peRow.sv
tests/clockGen.sv
tests/peRowTb.sv

/* tests/clockGen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module clockGen #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Reset held low for a few rising edges
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

/* tests/peRowPatterns.hex */
// Word 0 vector count. Per vector: length, flags (bit0 config, bit1 hold psumRdy),
// shift, zero point, activations, weights PE 0 to 3, expected result per PE index
0004
// Vector 0, first configuration shift 0 zp 10
0003 0001 0000 0010
0003 00fe 0005
0001 0002 0003
00ff 00ff 00ff
000a 0000 0004
0014 0001 001e
001e 0000 0042 00e0
// Vector 1, results held back to show grant order
0002 0002 0000 0000
0064 0064
0002 0002
00ff 0000
0001 0001
0003 0000
00a0 0000 00d8 003c
// Vector 2, config shift 2 zp 5 sent during vector 1
0003 0001 0002 0005
0032 00f6 0014
0004 0001 0002
0001 00fc 0000
00fe 0000 0001
007f 007f 007f
003e 001b 0000 0076
// Vector 3, single channel item
0001 0000 0000 0000
0080
0080
0001
0000
0002
0005 0000 0005 0000

/* tests/peRowTb.sv */
// Systolic PE row testbench
`timescale 1ns/1ps

module peRowTb;

    localparam int NUM_PE    = 4;
    localparam int PAT_DEPTH = 256;

    logic                     clk;
    logic                     arstN;
    logic                     actInVld;
    logic                     actInChnLast;
    logic [7:0]               actIn;
    logic                     actInRdy;
    logic                     actOutVld;
    logic                     actOutChnLast;
    logic [7:0]               actOut;
    logic                     actOutRdy;
    logic [NUM_PE-1:0]        wgtInVld;
    logic [NUM_PE-1:0]        wgtInChnLast;
    logic [NUM_PE-1:0][7:0]   wgtIn;
    logic [NUM_PE-1:0]        wgtInRdy;
    logic [NUM_PE-1:0]        wgtOutVld;
    logic [NUM_PE-1:0]        wgtOutChnLast;
    logic [NUM_PE-1:0][7:0]   wgtOut;
    logic [NUM_PE-1:0]        wgtOutRdy;
    logic                     cfgVld;
    logic [7:0]               cfgShift;
    logic [7:0]               cfgZp;
    logic                     psumVld;
    logic [7:0]               psum;
    logic [1:0]               psumIdx;
    logic                     psumRdy;
    logic                     rowIdle;

    logic [15:0] pat [0:PAT_DEPTH-1];
    int          vecBase [16];
    int          numVec;
    int          errorCount;
    int          cycles;
    int          cycleLimit;
    int          seed;
    logic        holdRdy;

    // Bookkeeping for the vector in flight
    int                curBase;
    int                curLen;
    logic              curOrdered;
    int                gotCount;
    int                prevIdx;
    int                aEcho;
    int                wEcho [NUM_PE];
    logic [NUM_PE-1:0] seen;

    clockGen #(.PERIOD(4.0), .RESET_CYCLES(3)) uClock (.clk(clk), .arstN(arstN));

    peRow #(.NUM_PE(NUM_PE)) dut (
        .clk(clk), .arstN(arstN),
        .actInVld(actInVld), .actInChnLast(actInChnLast), .actIn(actIn), .actInRdy(actInRdy),
        .actOutVld(actOutVld), .actOutChnLast(actOutChnLast), .actOut(actOut),
        .actOutRdy(actOutRdy),
        .wgtInVld(wgtInVld), .wgtInChnLast(wgtInChnLast), .wgtIn(wgtIn), .wgtInRdy(wgtInRdy),
        .wgtOutVld(wgtOutVld), .wgtOutChnLast(wgtOutChnLast), .wgtOut(wgtOut),
        .wgtOutRdy(wgtOutRdy),
        .cfgVld(cfgVld), .cfgShift(cfgShift), .cfgZp(cfgZp),
        .psumVld(psumVld), .psum(psum), .psumIdx(psumIdx), .psumRdy(psumRdy),
        .rowIdle(rowIdle)
    );

    // ==============================
    // Pattern access
    // ==============================

    function automatic logic [7:0] actAt(input int i);
        return pat[curBase + 4 + i][7:0];
    endfunction

    function automatic logic [7:0] wgtAt(input int k, input int i);
        return pat[curBase + 4 + curLen + k * curLen + i][7:0];
    endfunction

    function automatic logic [7:0] expAt(input int k);
        return pat[curBase + 4 + 5 * curLen + k][7:0];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportError(input string what);
        $display("Error at %0t: %s", $time, what);
        errorCount++;
    endtask

    // ==============================
    // Stimulus
    // ==============================

    task automatic sendConfig(input logic [7:0] shiftVal, input logic [7:0] zpVal);
        @(negedge clk);
        cfgVld   = 1'b1;
        cfgShift = shiftVal;
        cfgZp    = zpVal;
        @(negedge clk);
        cfgVld = 1'b0;
    endtask

    // Activations, weights and an optional config strobe after the last activation
    task automatic driveStreams(input logic sendCfg, input logic [7:0] nShift,
                                input logic [7:0] nZp);
        int                aPos;
        int                wPos [NUM_PE];
        logic              cfgDone;
        logic              aFire;
        logic [NUM_PE-1:0] wFire;
        logic              busy;
        aPos    = 0;
        cfgDone = !sendCfg;
        busy    = 1'b1;
        for (int k = 0; k < NUM_PE; k++) wPos[k] = 0;
        @(negedge clk);
        while (busy) begin
            actInVld     = (aPos < curLen);
            actInChnLast = (aPos == curLen - 1);
            if (aPos < curLen) actIn = actAt(aPos);
            for (int k = 0; k < NUM_PE; k++) begin
                wgtInVld[k]     = (wPos[k] < curLen);
                wgtInChnLast[k] = (wPos[k] == curLen - 1);
                if (wPos[k] < curLen) wgtIn[k] = wgtAt(k, wPos[k]);
            end
            cfgVld   = (aPos >= curLen) && !cfgDone;
            cfgShift = nShift;
            cfgZp    = nZp;
            #1;
            aFire = actInVld && actInRdy;
            wFire = wgtInVld & wgtInRdy;
            @(negedge clk);
            if (aFire) aPos++;
            if (cfgVld) cfgDone = 1'b1;
            busy = (aPos < curLen) || !cfgDone;
            for (int k = 0; k < NUM_PE; k++) begin
                if (wFire[k]) wPos[k]++;
                if (wPos[k] < curLen) busy = 1'b1;
            end
        end
        actInVld     = 1'b0;
        actInChnLast = 1'b0;
        wgtInVld     = '0;
        wgtInChnLast = '0;
        cfgVld       = 1'b0;
    endtask

    task automatic runVector(input int v);
        logic [15:0] flags;
        logic        nextCfg;
        int          nb;
        curBase    = vecBase[v];
        curLen     = pat[curBase];
        flags      = pat[curBase + 1];
        curOrdered = flags[1];
        gotCount   = 0;
        seen       = '0;
        aEcho      = 0;
        for (int k = 0; k < NUM_PE; k++) wEcho[k] = 0;
        if (v == 0 && flags[0]) sendConfig(pat[curBase + 2][7:0], pat[curBase + 3][7:0]);
        nb      = (v + 1 < numVec) ? vecBase[v + 1] : curBase;
        nextCfg = (v + 1 < numVec) && pat[nb + 1][0];
        // Results pile up so the arbiter sees several requests at once
        holdRdy = curOrdered;
        driveStreams(nextCfg, pat[nb + 2][7:0], pat[nb + 3][7:0]);
        if (curOrdered) begin
            @(posedge clk);
            holdRdy = 1'b0;
        end
        while (gotCount < NUM_PE) @(negedge clk);
        #1;
        while (!rowIdle) begin
            @(negedge clk);
            #1;
        end
        checkValue("actOut count", curLen, aEcho);
        for (int k = 0; k < NUM_PE; k++) begin
            checkValue($sformatf("wgtOut[%0d] count", k), curLen, wEcho[k]);
        end
    endtask

    // ==============================
    // Monitors
    // ==============================

    task automatic recordResult();
        int idx;
        idx = psumIdx;
        if (gotCount >= NUM_PE) begin
            reportError("more results than PEs for this vector");
        end else if (seen[idx]) begin
            reportError($sformatf("second result for PE %0d", idx));
        end else begin
            if (curOrdered && gotCount > 0) begin
                checkValue("psumIdx", (prevIdx + 1) % NUM_PE, idx);
            end
            checkValue($sformatf("psum[%0d]", idx), expAt(idx), psum);
            seen[idx] = 1'b1;
            gotCount++;
        end
        prevIdx = idx;
    endtask

    always @(negedge clk) begin
        #1;
        if (arstN) begin
            if (actOutVld && actOutRdy) begin
                if (aEcho >= curLen) begin
                    reportError("east activation beyond the stream length");
                end else begin
                    checkValue("actOut", actAt(aEcho), actOut);
                    checkValue("actOutChnLast", aEcho == curLen - 1, actOutChnLast);
                end
                aEcho++;
            end
            for (int k = 0; k < NUM_PE; k++) begin
                if (wgtOutVld[k] && wgtOutRdy[k]) begin
                    if (wEcho[k] >= curLen) begin
                        reportError($sformatf("south weight %0d beyond the stream length", k));
                    end else begin
                        checkValue($sformatf("wgtOut[%0d]", k), wgtAt(k, wEcho[k]), wgtOut[k]);
                        checkValue($sformatf("wgtOutChnLast[%0d]", k),
                                   wEcho[k] == curLen - 1, wgtOutChnLast[k]);
                    end
                    wEcho[k]++;
                end
            end
            if (psumVld && psumRdy) recordResult();
        end
    end

    // Random back-pressure on the result port
    always @(negedge clk) begin
        psumRdy = holdRdy ? 1'b0 : (($random(seed) & 1) != 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int base;
        int len;
        seed         = 32'hb8b9;
        errorCount   = 0;
        cycles       = 0;
        holdRdy      = 1'b0;
        curBase      = 1;
        curLen       = 0;
        curOrdered   = 1'b0;
        gotCount     = 0;
        prevIdx      = 0;
        aEcho        = 0;
        seen         = '0;
        actInVld     = 1'b0;
        actInChnLast = 1'b0;
        actIn        = '0;
        actOutRdy    = 1'b1;
        wgtInVld     = '0;
        wgtInChnLast = '0;
        wgtIn        = '0;
        wgtOutRdy    = '1;
        cfgVld       = 1'b0;
        cfgShift     = '0;
        cfgZp        = '0;
        psumRdy      = 1'b0;
        $readmemh("tests/peRowPatterns.hex", pat);
        numVec = pat[0];
        base   = 1;
        // Startup allowance plus a budget per vector
        cycleLimit = 200;
        for (int v = 0; v < numVec; v++) begin
            vecBase[v] = base;
            len        = pat[base];
            cycleLimit += (len + NUM_PE) * 8;
            base       += 8 + 5 * len;
        end

        wait (arstN === 1'b1);
        @(negedge clk);
        #1;
        checkValue("psumVld", 0, psumVld);
        checkValue("actOutVld", 0, actOutVld);
        checkValue("wgtOutVld", 0, wgtOutVld);
        checkValue("rowIdle", 1, rowIdle);
        checkValue("actInRdy", 0, actInRdy);
        checkValue("wgtInRdy", 0, wgtInRdy);
        repeat (2) @(negedge clk);
        #1;
        checkValue("actInRdy", 0, actInRdy);

        for (int v = 0; v < numVec; v++) runVector(v);

        $display("Checks done, %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/actLinkIf.sv */
// Activation valid/ready link
`timescale 1ns/1ps

interface actLinkIf #(
    parameter int ACT_WIDTH = sysRowPkg::ACT_WIDTH_DEF
) ();

    logic                 vld;
    // Marks the last item of a channel
    logic                 chnLast;
    logic [ACT_WIDTH-1:0] act;
    logic                 rdy;

    // Upstream side of a link
    modport src (
        output vld, chnLast, act,
        input  rdy
    );

    // Downstream side of a link
    modport dst (
        input  vld, chnLast, act,
        output rdy
    );

endinterface

/* verilog/peRow.sv */
// Systolic PE row top level
`timescale 1ns/1ps

module peRow #(
    parameter int  ACT_WIDTH  = sysRowPkg::ACT_WIDTH_DEF,
    parameter int  WGT_WIDTH  = sysRowPkg::WGT_WIDTH_DEF,
    parameter int  CHN_WIDTH  = sysRowPkg::CHN_WIDTH_DEF,
    parameter int  NUM_PE     = sysRowPkg::NUM_PE_DEF,
    localparam int PSUM_WIDTH = ACT_WIDTH + WGT_WIDTH + CHN_WIDTH,
    localparam int IDX_WIDTH  = (NUM_PE > 1) ? $clog2(NUM_PE) : 1
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              actInVld,
    input  logic                              actInChnLast,
    input  logic [ACT_WIDTH-1:0]              actIn,
    output logic                              actInRdy,
    output logic                              actOutVld,
    output logic                              actOutChnLast,
    output logic [ACT_WIDTH-1:0]              actOut,
    input  logic                              actOutRdy,
    input  logic [NUM_PE-1:0]                 wgtInVld,
    input  logic [NUM_PE-1:0]                 wgtInChnLast,
    input  logic [NUM_PE-1:0][WGT_WIDTH-1:0]  wgtIn,
    output logic [NUM_PE-1:0]                 wgtInRdy,
    output logic [NUM_PE-1:0]                 wgtOutVld,
    output logic [NUM_PE-1:0]                 wgtOutChnLast,
    output logic [NUM_PE-1:0][WGT_WIDTH-1:0]  wgtOut,
    input  logic [NUM_PE-1:0]                 wgtOutRdy,
    input  logic                              cfgVld,
    input  logic [ACT_WIDTH-1:0]              cfgShift,
    input  logic [ACT_WIDTH-1:0]              cfgZp,
    output logic                              psumVld,
    output logic [ACT_WIDTH-1:0]              psum,
    output logic [IDX_WIDTH-1:0]              psumIdx,
    input  logic                              psumRdy,
    output logic                              rowIdle
);

    // Link k feeds PE k from the west
    actLinkIf #(.ACT_WIDTH(ACT_WIDTH)) link [NUM_PE:0] ();

    logic [NUM_PE-1:0]                 pePsumVld;
    logic [NUM_PE-1:0]                 pePsumRdy;
    logic [NUM_PE-1:0][PSUM_WIDTH-1:0] pePsum;
    logic [NUM_PE-1:0]                 peBusy;
    logic [NUM_PE-1:0]                 gnt;
    logic [IDX_WIDTH-1:0]              gntIdx;
    logic                              taken;
    logic                              actEnable;
    logic [ACT_WIDTH-1:0]              shift;
    logic [ACT_WIDTH-1:0]              zp;

    // ==============================
    // Row edges
    // ==============================

    // West input closed until configured
    assign link[0].vld     = actInVld && actEnable;
    assign link[0].chnLast = actInChnLast;
    assign link[0].act     = actIn;
    assign actInRdy        = link[0].rdy && actEnable;

    assign actOutVld           = link[NUM_PE].vld;
    assign actOutChnLast       = link[NUM_PE].chnLast;
    assign actOut              = link[NUM_PE].act;
    assign link[NUM_PE].rdy    = actOutRdy;

    // ==============================
    // PE chain
    // ==============================

    for (genvar k = 0; k < NUM_PE; k++) begin : genPe
        processingElement #(
            .ACT_WIDTH (ACT_WIDTH),
            .WGT_WIDTH (WGT_WIDTH),
            .CHN_WIDTH (CHN_WIDTH)
        ) uPe (
            .clk           (clk),
            .arstN         (arstN),
            .west          (link[k]),
            .east          (link[k+1]),
            .wgtInVld      (wgtInVld[k]),
            .wgtInChnLast  (wgtInChnLast[k]),
            .wgtIn         (wgtIn[k]),
            .wgtInRdy      (wgtInRdy[k]),
            .wgtOutVld     (wgtOutVld[k]),
            .wgtOutChnLast (wgtOutChnLast[k]),
            .wgtOut        (wgtOut[k]),
            .wgtOutRdy     (wgtOutRdy[k]),
            .psumVld       (pePsumVld[k]),
            .psum          (pePsum[k]),
            .psumRdy       (pePsumRdy[k])
        );

        // Anything still in flight out of this PE
        assign peBusy[k] = link[k+1].vld || wgtOutVld[k] || pePsumVld[k];
    end

    // Only the granted PE sees its psum taken
    assign pePsumRdy = gnt & {NUM_PE{taken}};

    rrArbiter #(
        .NUM_PE (NUM_PE)
    ) uArbiter (
        .clk     (clk),
        .arstN   (arstN),
        .advance (taken),
        .req     (pePsumVld),
        .gnt     (gnt),
        .gntIdx  (gntIdx)
    );

    psumRequant #(
        .ACT_WIDTH (ACT_WIDTH),
        .WGT_WIDTH (WGT_WIDTH),
        .CHN_WIDTH (CHN_WIDTH),
        .NUM_PE    (NUM_PE)
    ) uRequant (
        .clk      (clk),
        .arstN    (arstN),
        .inVld    (|pePsumVld),
        .inPsum   (pePsum[gntIdx]),
        .inIdx    (gntIdx),
        .taken    (taken),
        .cfgShift (shift),
        .cfgZp    (zp),
        .outVld   (psumVld),
        .outAct   (psum),
        .outIdx   (psumIdx),
        .outRdy   (psumRdy)
    );

    rowCtrl #(
        .ACT_WIDTH (ACT_WIDTH),
        .NUM_PE    (NUM_PE)
    ) uCtrl (
        .clk       (clk),
        .arstN     (arstN),
        .cfgVld    (cfgVld),
        .cfgShift  (cfgShift),
        .cfgZp     (cfgZp),
        .shift     (shift),
        .zp        (zp),
        .actEnable (actEnable),
        .peBusy    (peBusy),
        .outVld    (psumVld),
        .rowIdle   (rowIdle)
    );

endmodule

/* verilog/processingElement.sv */
// Systolic MAC processing element
`timescale 1ns/1ps

module processingElement #(
    parameter int  ACT_WIDTH  = sysRowPkg::ACT_WIDTH_DEF,
    parameter int  WGT_WIDTH  = sysRowPkg::WGT_WIDTH_DEF,
    parameter int  CHN_WIDTH  = sysRowPkg::CHN_WIDTH_DEF,
    localparam int PSUM_WIDTH = ACT_WIDTH + WGT_WIDTH + CHN_WIDTH
) (
    input  logic                         clk,
    input  logic                         arstN,
    actLinkIf.dst                        west,
    actLinkIf.src                        east,
    input  logic                         wgtInVld,
    input  logic                         wgtInChnLast,
    input  logic [WGT_WIDTH-1:0]         wgtIn,
    output logic                         wgtInRdy,
    output logic                         wgtOutVld,
    output logic                         wgtOutChnLast,
    output logic [WGT_WIDTH-1:0]         wgtOut,
    input  logic                         wgtOutRdy,
    output logic                         psumVld,
    output logic signed [PSUM_WIDTH-1:0] psum,
    input  logic                         psumRdy
);

    sysRowPkg::peState_e state;

    logic eastFree;
    logic southFree;
    logic canTake;
    logic accept;

    logic signed [ACT_WIDTH+WGT_WIDTH-1:0] product;
    logic signed [PSUM_WIDTH-1:0]          acc;
    logic signed [PSUM_WIDTH-1:0]          accNext;
    logic signed [PSUM_WIDTH-1:0]          psumHeld;

    logic                 eastVldQ;
    logic                 eastChnLastQ;
    logic [ACT_WIDTH-1:0] eastActQ;

    // ==============================
    // Joint handshake
    // ==============================

    // Output stage can take a new item
    assign eastFree  = !eastVldQ || east.rdy;
    assign southFree = !wgtOutVld || wgtOutRdy;
    assign canTake   = (state == sysRowPkg::ACCUM) && eastFree && southFree;

    // Activation and weight move together
    assign west.rdy = canTake && wgtInVld;
    assign wgtInRdy = canTake && west.vld;
    assign accept   = canTake && west.vld && wgtInVld;

    assign product = $signed(west.act) * $signed(wgtIn);
    assign accNext = acc + product;

    // ==============================
    // Control state
    // ==============================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= sysRowPkg::ACCUM;
            acc       <= '0;
            eastVldQ  <= 1'b0;
            wgtOutVld <= 1'b0;
        end else begin
            if (accept) begin
                eastVldQ <= 1'b1;
            end else if (east.rdy) begin
                eastVldQ <= 1'b0;
            end
            if (accept) begin
                wgtOutVld <= 1'b1;
            end else if (wgtOutRdy) begin
                wgtOutVld <= 1'b0;
            end
            case (state)
                sysRowPkg::ACCUM: begin
                    if (accept && west.chnLast) begin
                        // Sum complete and accumulator restarts for next channel
                        acc   <= '0;
                        state <= sysRowPkg::HOLD;
                    end else if (accept) begin
                        acc <= accNext;
                    end
                end
                sysRowPkg::HOLD: begin
                    if (psumRdy) begin
                        state <= sysRowPkg::ACCUM;
                    end
                end
            endcase
        end
    end

    // Forwarded data and held sum
    always_ff @(posedge clk) begin
        if (accept) begin
            eastActQ      <= west.act;
            eastChnLastQ  <= west.chnLast;
            wgtOut        <= wgtIn;
            wgtOutChnLast <= wgtInChnLast;
        end
        if (accept && west.chnLast) begin
            psumHeld <= accNext;
        end
    end

    assign east.vld     = eastVldQ;
    assign east.chnLast = eastChnLastQ;
    assign east.act     = eastActQ;

    assign psumVld = (state == sysRowPkg::HOLD);
    assign psum    = psumHeld;

endmodule

/* verilog/psumRequant.sv */
// Psum requantizer stage
`timescale 1ns/1ps

module psumRequant #(
    parameter int  ACT_WIDTH  = sysRowPkg::ACT_WIDTH_DEF,
    parameter int  WGT_WIDTH  = sysRowPkg::WGT_WIDTH_DEF,
    parameter int  CHN_WIDTH  = sysRowPkg::CHN_WIDTH_DEF,
    parameter int  NUM_PE     = sysRowPkg::NUM_PE_DEF,
    localparam int PSUM_WIDTH = ACT_WIDTH + WGT_WIDTH + CHN_WIDTH,
    localparam int IDX_WIDTH  = (NUM_PE > 1) ? $clog2(NUM_PE) : 1
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         inVld,
    input  logic signed [PSUM_WIDTH-1:0] inPsum,
    input  logic [IDX_WIDTH-1:0]         inIdx,
    output logic                         taken,
    input  logic [ACT_WIDTH-1:0]         cfgShift,
    input  logic [ACT_WIDTH-1:0]         cfgZp,
    output logic                         outVld,
    output logic [ACT_WIDTH-1:0]         outAct,
    output logic [IDX_WIDTH-1:0]         outIdx,
    input  logic                         outRdy
);

    logic [PSUM_WIDTH-1:0] shifted;
    logic [ACT_WIDTH-1:0]  actNext;

    // Register empty or draining this cycle
    assign taken = inVld && (!outVld || outRdy);

    // Bits above the sum read as zero for large shifts
    assign shifted = $unsigned(inPsum) >> cfgShift;

    // Negative sums clamp to zero and the zero point add wraps
    assign actNext = inPsum[PSUM_WIDTH-1] ? '0 : shifted[ACT_WIDTH-1:0] + cfgZp;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outVld <= 1'b0;
        end else if (taken) begin
            outVld <= 1'b1;
        end else if (outRdy) begin
            outVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            outAct <= actNext;
            outIdx <= inIdx;
        end
    end

endmodule

/* verilog/rowCtrl.sv */
// Row configuration controller
`timescale 1ns/1ps

module rowCtrl #(
    parameter int ACT_WIDTH = sysRowPkg::ACT_WIDTH_DEF,
    parameter int NUM_PE    = sysRowPkg::NUM_PE_DEF
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 cfgVld,
    input  logic [ACT_WIDTH-1:0] cfgShift,
    input  logic [ACT_WIDTH-1:0] cfgZp,
    output logic [ACT_WIDTH-1:0] shift,
    output logic [ACT_WIDTH-1:0] zp,
    output logic                 actEnable,
    input  logic [NUM_PE-1:0]    peBusy,
    input  logic                 outVld,
    output logic                 rowIdle
);

    sysRowPkg::rowState_e state;

    // Configuration waiting for the row to drain
    logic [ACT_WIDTH-1:0] pendShift;
    logic [ACT_WIDTH-1:0] pendZp;

    assign rowIdle   = !(|peBusy) && !outVld;
    assign actEnable = (state == sysRowPkg::READY);

    // ==============================
    // Row state machine
    // ==============================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sysRowPkg::UNCONFIGURED;
            shift <= '0;
            zp    <= '0;
        end else begin
            case (state)
                sysRowPkg::UNCONFIGURED: begin
                    if (cfgVld) begin
                        shift <= cfgShift;
                        zp    <= cfgZp;
                        state <= sysRowPkg::READY;
                    end
                end
                sysRowPkg::READY: begin
                    if (cfgVld && rowIdle) begin
                        shift <= cfgShift;
                        zp    <= cfgZp;
                    end else if (cfgVld) begin
                        state <= sysRowPkg::DRAIN;
                    end
                end
                sysRowPkg::DRAIN: begin
                    // Latest strobe wins if it lands on the exit cycle
                    if (rowIdle) begin
                        shift <= cfgVld ? cfgShift : pendShift;
                        zp    <= cfgVld ? cfgZp : pendZp;
                        state <= sysRowPkg::READY;
                    end
                end
                default: state <= sysRowPkg::UNCONFIGURED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cfgVld) begin
            pendShift <= cfgShift;
            pendZp    <= cfgZp;
        end
    end

endmodule

/* verilog/rrArbiter.sv */
// Round-robin psum arbiter
`timescale 1ns/1ps

module rrArbiter #(
    parameter int  NUM_PE    = sysRowPkg::NUM_PE_DEF,
    localparam int IDX_WIDTH = (NUM_PE > 1) ? $clog2(NUM_PE) : 1
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 advance,
    input  logic [NUM_PE-1:0]    req,
    output logic [NUM_PE-1:0]    gnt,
    output logic [IDX_WIDTH-1:0] gntIdx
);

    // Index granted most recently
    logic [IDX_WIDTH-1:0] lastIdx;

    logic found;
    int   cand;

    // Search starts just after the last grant and wraps around
    always_comb begin
        gnt    = '0;
        gntIdx = '0;
        found  = 1'b0;
        cand   = 0;
        for (int i = 1; i <= NUM_PE; i++) begin
            cand = (int'(lastIdx) + i) % NUM_PE;
            if (!found && req[cand]) begin
                found       = 1'b1;
                gnt[cand]   = 1'b1;
                gntIdx      = IDX_WIDTH'(cand);
            end
        end
    end

    // ==============================
    // Priority pointer
    // ==============================

    // Index 0 wins first after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastIdx <= IDX_WIDTH'(NUM_PE - 1);
        end else if (advance) begin
            lastIdx <= gntIdx;
        end
    end

endmodule

/* verilog/sysRowPkg.sv */
// Systolic row shared definitions
package sysRowPkg;

    // ==============================
    // Default widths and row length
    // ==============================

    // Signed activation width
    localparam int ACT_WIDTH_DEF = 8;

    // Signed weight width
    localparam int WGT_WIDTH_DEF = 8;

    // Headroom bits for channel accumulation
    localparam int CHN_WIDTH_DEF = 8;

    // PEs in one row
    localparam int NUM_PE_DEF = 4;

    // ==============================
    // State encodings
    // ==============================

    // Row controller states
    typedef enum logic [1:0] {
        UNCONFIGURED,
        READY,
        DRAIN
    } rowState_e;

    // PE accumulation states
    typedef enum logic {
        ACCUM,
        HOLD
    } peState_e;

endpackage
